// ==== logic/raise_freq_pkg.sv ====
package raise_freq_pkg;

        // fixed-point word types
        typedef logic signed [15:0] sample_t;
        typedef logic [31:0] cplx_t;
        typedef logic signed [15:0] angle_t;
        typedef logic [5:0] bin_t;
        typedef logic [3:0] iter_t;

        typedef enum logic [3:0] {
                st_idle,
                st_vector,
                st_vec_fix,
                st_diff,
                st_accum,
                st_fold,
                st_rotate,
                st_rot_fix,
                st_done
        } ctrl_state_t;

        localparam int num_bins = 64;
        localparam bin_t last_bin = 6'd63;
        localparam int cordic_iters = 8;
        localparam int gain_comp = 39;
        localparam int frac_shift = 6;
        localparam int half_turn = 180;
        localparam int quarter_turn = 90;
        localparam int half_turn_fx = 11520;
        localparam int gain_knee = 512;
        localparam int result_latency = 22;

        // atan(2^-i) in degrees times 64
        localparam angle_t atan_table [cordic_iters] = '{
                16'sd2880, 16'sd1700, 16'sd898, 16'sd456,
                16'sd229, 16'sd115, 16'sd57, 16'sd29
        };

        // multiply by 39/64, shifting first for large magnitudes
        function automatic sample_t gain_scale(input sample_t m);
                logic signed [31:0] wide;
                if (m > gain_knee)
                        wide = (32'(m) >>> frac_shift) * gain_comp;
                else
                        wide = (32'(m) * gain_comp) >>> frac_shift;
                return sample_t'(wide);
        endfunction

endpackage

// ==== logic/iter_counter.sv ====
`timescale 1ns/1ps

module iter_counter import raise_freq_pkg::*; (
        input  logic  clk,
        input  logic  rst,
        input  logic  cnt_clear,
        output iter_t iter,
        output logic  iter_last
);

        always_ff @(posedge clk) begin
                if (rst || cnt_clear)
                        iter <= '0;
                else
                        iter <= iter + 4'd1;
        end

        assign iter_last = (iter == iter_t'(cordic_iters - 1));

endmodule

// ==== logic/bin_ctrl.sv ====
`timescale 1ns/1ps

module bin_ctrl import raise_freq_pkg::*; (
        input  logic clk,
        input  logic rst,
        input  logic fft1_valid,
        input  logic fft2_valid,
        input  logic iter_last,
        output logic load,
        output logic vec_step,
        output logic vec_fix,
        output logic diff_en,
        output logic accum_en,
        output logic fold_en,
        output logic rot_step,
        output logic rot_fix,
        output logic out_en,
        output logic cnt_clear,
        output logic raise_valid
);

        ctrl_state_t state;
        ctrl_state_t next_state;

        always_comb begin
                next_state = state;
                case (state)
                        st_idle: begin
                                if (fft1_valid && fft2_valid)
                                        next_state = st_vector;
                        end
                        st_vector: begin
                                if (iter_last)
                                        next_state = st_vec_fix;
                        end
                        st_vec_fix: next_state = st_diff;
                        st_diff:    next_state = st_accum;
                        st_accum:   next_state = st_fold;
                        st_fold:    next_state = st_rotate;
                        st_rotate: begin
                                if (iter_last)
                                        next_state = st_rot_fix;
                        end
                        st_rot_fix: next_state = st_done;
                        default:    next_state = st_idle;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= st_idle;
                        raise_valid <= 1'b0;
                end else begin
                        state <= next_state;
                        // pulse lines up with freq_out being latched
                        raise_valid <= out_en;
                end
        end

        // a pair is only taken when both halves arrive together
        assign load = (state == st_idle) && fft1_valid && fft2_valid;
        assign vec_step = (state == st_vector);
        assign vec_fix = (state == st_vec_fix);
        assign diff_en = (state == st_diff);
        assign accum_en = (state == st_accum);
        assign fold_en = (state == st_fold);
        assign rot_step = (state == st_rotate);
        assign rot_fix = (state == st_rot_fix);
        assign out_en = (state == st_done);

        // counter starts at zero on the first step of each CORDIC pass
        assign cnt_clear = load || fold_en;

endmodule

// ==== logic/cordic_vector.sv ====
`timescale 1ns/1ps

module cordic_vector import raise_freq_pkg::*; (
        input  logic    clk,
        input  logic    rst,
        input  cplx_t   sample,
        input  logic    load,
        input  logic    vec_step,
        input  logic    vec_fix,
        input  iter_t   iter,
        output angle_t  angle,
        output sample_t mag
);

        sample_t re;
        sample_t im;
        sample_t x;
        sample_t y;
        angle_t  z;
        logic    is_left;
        logic    is_low;

        assign re = sample[31:16];
        assign im = sample[15:0];

        always_ff @(posedge clk) begin
                if (load) begin
                        // mirror the left half-plane onto the right
                        is_left <= (re < 0);
                        is_low <= (im < 0);
                        x <= (re < 0) ? -re : re;
                        y <= im;
                        z <= '0;
                end else if (vec_step) begin
                        // drive y towards zero
                        if (y >= 0) begin
                                x <= x + (y >>> iter);
                                y <= y - (x >>> iter);
                                z <= z + atan_table[iter[2:0]];
                        end else begin
                                x <= x - (y >>> iter);
                                y <= y + (x >>> iter);
                                z <= z - atan_table[iter[2:0]];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        angle <= '0;
                        mag <= '0;
                end else if (vec_fix) begin
                        if (!is_left)
                                angle <= z >>> frac_shift;
                        else if (!is_low)
                                angle <= angle_t'((half_turn_fx - z) >>> frac_shift);
                        else
                                angle <= angle_t'((-half_turn_fx - z) >>> frac_shift);
                        // undo the CORDIC gain
                        mag <= gain_scale(x);
                end
        end

endmodule

// ==== logic/phase_store.sv ====
`timescale 1ns/1ps

module phase_store import raise_freq_pkg::*; (
        input  logic   clk,
        input  logic   rst,
        input  bin_t   freq1,
        input  logic   load,
        input  logic   diff_en,
        input  logic   accum_en,
        input  logic   out_en,
        input  angle_t angle1,
        input  angle_t angle2,
        output angle_t phase,
        output bin_t   freq_out,
        output logic   raise_fin
);

        bin_t   cur_bin;
        angle_t phase_mem [num_bins];
        angle_t new_phase;

        // bring an angle back into -180..180
        function automatic angle_t wrap_angle(input angle_t a);
                angle_t w;
                if (a > half_turn)
                        w = angle_t'(a - 2 * half_turn);
                else if (a < -half_turn)
                        w = angle_t'(a + 2 * half_turn);
                else
                        w = a;
                return w;
        endfunction

        assign new_phase = wrap_angle(phase + phase_mem[cur_bin]);

        always_ff @(posedge clk) begin
                if (load)
                        cur_bin <= freq1;
                if (diff_en)
                        phase <= wrap_angle(angle2 - angle1);
                else if (accum_en)
                        phase <= new_phase;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < num_bins; i++)
                                phase_mem[i] <= '0;
                end else if (accum_en) begin
                        phase_mem[cur_bin] <= new_phase;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        freq_out <= '0;
                        raise_fin <= 1'b0;
                end else if (out_en) begin
                        freq_out <= cur_bin;
                        raise_fin <= (cur_bin == last_bin);
                end
        end

endmodule

// ==== logic/cordic_rotate.sv ====
`timescale 1ns/1ps

module cordic_rotate import raise_freq_pkg::*; (
        input  logic    clk,
        input  logic    rst,
        input  angle_t  phase,
        input  sample_t mag,
        input  logic    fold_en,
        input  logic    rot_step,
        input  logic    rot_fix,
        input  iter_t   iter,
        output cplx_t   raise_data
);

        sample_t x;
        sample_t y;
        angle_t  z;
        logic    folded;

        always_ff @(posedge clk) begin
                if (fold_en) begin
                        // keep the rotation inside the CORDIC range
                        if (phase > quarter_turn) begin
                                folded <= 1'b1;
                                z <= angle_t'((half_turn - phase) <<< frac_shift);
                        end else if (phase < -quarter_turn) begin
                                folded <= 1'b1;
                                z <= angle_t'((-half_turn - phase) <<< frac_shift);
                        end else begin
                                folded <= 1'b0;
                                z <= phase <<< frac_shift;
                        end
                        // prescale so the CORDIC gain cancels
                        x <= gain_scale(mag);
                        y <= '0;
                end else if (rot_step) begin
                        if (z >= 0) begin
                                x <= x - (y >>> iter);
                                y <= y + (x >>> iter);
                                z <= z - atan_table[iter[2:0]];
                        end else begin
                                x <= x + (y >>> iter);
                                y <= y - (x >>> iter);
                                z <= z + atan_table[iter[2:0]];
                        end
                end
        end

        // real part in the upper half
        always_ff @(posedge clk) begin
                if (rst)
                        raise_data <= '0;
                else if (rot_fix)
                        raise_data <= {folded ? -x : x, y};
        end

endmodule

// ==== logic/raise_freq_top.sv ====
`timescale 1ns/1ps

module raise_freq_top import raise_freq_pkg::*; (
        input  logic  clk,
        input  logic  rst,
        input  cplx_t fft1_data,
        input  logic  fft1_valid,
        input  cplx_t fft2_data,
        input  logic  fft2_valid,
        input  bin_t  freq1,
        output cplx_t raise_data,
        output logic  raise_valid,
        output logic  raise_fin,
        output bin_t  freq_out
);

        // controller strobes
        logic load;
        logic vec_step;
        logic vec_fix;
        logic diff_en;
        logic accum_en;
        logic fold_en;
        logic rot_step;
        logic rot_fix;
        logic out_en;
        logic cnt_clear;

        iter_t   iter;
        logic    iter_last;
        angle_t  angle1;
        angle_t  angle2;
        sample_t mag2;
        angle_t  phase;

        bin_ctrl i_bin_ctrl (
                .clk         (clk),
                .rst         (rst),
                .fft1_valid  (fft1_valid),
                .fft2_valid  (fft2_valid),
                .iter_last   (iter_last),
                .load        (load),
                .vec_step    (vec_step),
                .vec_fix     (vec_fix),
                .diff_en     (diff_en),
                .accum_en    (accum_en),
                .fold_en     (fold_en),
                .rot_step    (rot_step),
                .rot_fix     (rot_fix),
                .out_en      (out_en),
                .cnt_clear   (cnt_clear),
                .raise_valid (raise_valid)
        );

        iter_counter i_iter_counter (
                .clk       (clk),
                .rst       (rst),
                .cnt_clear (cnt_clear),
                .iter      (iter),
                .iter_last (iter_last)
        );

        // sample 1 only contributes its angle
        cordic_vector i_cordic_vector1 (
                .clk      (clk),
                .rst      (rst),
                .sample   (fft1_data),
                .load     (load),
                .vec_step (vec_step),
                .vec_fix  (vec_fix),
                .iter     (iter),
                .angle    (angle1),
                .mag      ()
        );

        cordic_vector i_cordic_vector2 (
                .clk      (clk),
                .rst      (rst),
                .sample   (fft2_data),
                .load     (load),
                .vec_step (vec_step),
                .vec_fix  (vec_fix),
                .iter     (iter),
                .angle    (angle2),
                .mag      (mag2)
        );

        phase_store i_phase_store (
                .clk       (clk),
                .rst       (rst),
                .freq1     (freq1),
                .load      (load),
                .diff_en   (diff_en),
                .accum_en  (accum_en),
                .out_en    (out_en),
                .angle1    (angle1),
                .angle2    (angle2),
                .phase     (phase),
                .freq_out  (freq_out),
                .raise_fin (raise_fin)
        );

        cordic_rotate i_cordic_rotate (
                .clk        (clk),
                .rst        (rst),
                .phase      (phase),
                .mag        (mag2),
                .fold_en    (fold_en),
                .rot_step   (rot_step),
                .rot_fix    (rot_fix),
                .iter       (iter),
                .raise_data (raise_data)
        );

endmodule

// ==== sim/raise_freq_asserts.sv ====
`timescale 1ns/1ps

module raise_freq_asserts import raise_freq_pkg::*; (
        input logic  clk,
        input logic  rst,
        input cplx_t raise_data,
        input logic  raise_valid,
        input logic  raise_fin,
        input bin_t  freq_out
);

        // one pulse per result
        valid_single_pulse: assert property (@(posedge clk) disable iff (rst)
                raise_valid |=> !raise_valid)
                else $error("raise_valid high for two cycles");

        // bin index and fin level only move together with a result
        outputs_held: assert property (@(posedge clk) disable iff (rst)
                (!$stable(freq_out) || !$stable(raise_fin)) |-> raise_valid)
                else $error("freq_out or raise_fin changed without a result");

        // sync reset clears the outputs by the next edge
        reset_idle: assert property (@(posedge clk)
                rst |=> (!raise_valid && !raise_fin && raise_data == '0 && freq_out == '0))
                else $error("outputs not idle during reset");

endmodule

bind raise_freq_top raise_freq_asserts i_raise_freq_asserts (
        .clk         (clk),
        .rst         (rst),
        .raise_data  (raise_data),
        .raise_valid (raise_valid),
        .raise_fin   (raise_fin),
        .freq_out    (freq_out)
);

// ==== sim/raise_freq_tb.sv ====
`timescale 1ns/1ps

module raise_freq_tb import raise_freq_pkg::*; ();

        localparam int watch_cycles = 30;

        logic  clk;
        logic  rst;
        cplx_t fft1_data;
        logic  fft1_valid;
        cplx_t fft2_data;
        logic  fft2_valid;
        bin_t  freq1;
        cplx_t raise_data;
        logic  raise_valid;
        logic  raise_fin;
        bin_t  freq_out;

        // one entry per data line
        int mode_q[$];
        int bin_q[$];
        int r1_q[$];
        int i1_q[$];
        int r2_q[$];
        int i2_q[$];
        int exp_re_q[$];
        int exp_im_q[$];
        int tol_q[$];

        int cycle_count;
        int cycle_limit;

        raise_freq_top i_raise_freq_top (
                .clk         (clk),
                .rst         (rst),
                .fft1_data   (fft1_data),
                .fft1_valid  (fft1_valid),
                .fft2_data   (fft2_data),
                .fft2_valid  (fft2_valid),
                .freq1       (freq1),
                .raise_data  (raise_data),
                .raise_valid (raise_valid),
                .raise_fin   (raise_fin),
                .freq_out    (freq_out)
        );

        always #20 clk = ~clk;

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= cycle_limit) begin
                        $display("timeout after %0d cycles", cycle_count);
                        $display("TESTS FAILED");
                        $fatal(1, "simulation timed out");
                end
        end

        task automatic check_value(input string name, input int got, input int expected,
                                   input int tol);
                int diff;
                diff = got - expected;
                if (diff < 0)
                        diff = -diff;
                if (diff > tol) begin
                        $display("ERR t=%0t %s got=%0d expected=%0d", $time, name, got, expected);
                        $display("TESTS FAILED");
                        $fatal(1, "value mismatch");
                end
        endtask

        task automatic stop_with(input string reason);
                $display("%s", reason);
                $display("TESTS FAILED");
                $fatal(1, "run aborted");
        endtask

        task automatic read_stimulus();
                int fd;
                int n;
                int fields;
                int b;
                int r1;
                int i1;
                int r2;
                int i2;
                int er;
                int ei;
                int tl;
                string line;
                logic [63:0] mode_word;
                fd = $fopen("sim/raise_freq_input.txt", "r");
                if (fd == 0)
                        stop_with("cannot open sim/raise_freq_input.txt");
                while (!$feof(fd)) begin
                        line = "";
                        n = $fgets(line, fd);
                        // skip blank lines and the column header
                        if (n > 1 && line[0] != 8'h23) begin
                                fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d",
                                                 mode_word, b, r1, i1, r2, i2, er, ei, tl);
                                if (fields != 9)
                                        stop_with("malformed line in the stimulus file");
                                if (mode_word == 64'("pair"))
                                        mode_q.push_back(0);
                                else if (mode_word == 64'("single"))
                                        mode_q.push_back(1);
                                else if (mode_word == 64'("spacing"))
                                        mode_q.push_back(2);
                                else
                                        stop_with("unknown mode in the stimulus file");
                                bin_q.push_back(b);
                                r1_q.push_back(r1);
                                i1_q.push_back(i1);
                                r2_q.push_back(r2);
                                i2_q.push_back(i2);
                                exp_re_q.push_back(er);
                                exp_im_q.push_back(ei);
                                tol_q.push_back(tl);
                        end
                end
                $fclose(fd);
        endtask

        task automatic apply_pair(input int idx, input bit hold_busy);
                int count;
                int b;
                sample_t re;
                sample_t im;
                b = bin_q[idx];
                fft1_data = {16'(r1_q[idx]), 16'(i1_q[idx])};
                fft2_data = {16'(r2_q[idx]), 16'(i2_q[idx])};
                freq1 = 6'(b);
                fft1_valid = 1'b1;
                fft2_valid = 1'b1;
                // acceptance edge
                @(posedge clk);
                #2;
                if (hold_busy) begin
                        // another pair for another bin while busy, must be dropped
                        fft1_data = ~fft1_data;
                        fft2_data = {fft2_data[15:0], fft2_data[31:16]};
                        freq1 = 6'(b + 1);
                end else begin
                        fft1_valid = 1'b0;
                        fft2_valid = 1'b0;
                end
                count = 0;
                while (raise_valid !== 1'b1 && count < watch_cycles) begin
                        @(posedge clk);
                        #2;
                        count++;
                end
                fft1_valid = 1'b0;
                fft2_valid = 1'b0;
                if (raise_valid !== 1'b1)
                        stop_with($sformatf("no raise_valid for data line %0d", idx + 1));
                check_value("result latency", count, result_latency, 0);
                re = raise_data[31:16];
                im = raise_data[15:0];
                check_value("raise_data real", int'(re), exp_re_q[idx], tol_q[idx]);
                check_value("raise_data imag", int'(im), exp_im_q[idx], tol_q[idx]);
                check_value("freq_out", int'(freq_out), b, 0);
                check_value("raise_fin", int'(raise_fin), (b == 63) ? 1 : 0, 0);
                @(posedge clk);
                #2;
                check_value("raise_valid", int'(raise_valid), 0, 0);
        endtask

        task automatic apply_single(input int idx);
                fft1_data = {16'(r1_q[idx]), 16'(i1_q[idx])};
                fft2_data = {16'(r2_q[idx]), 16'(i2_q[idx])};
                freq1 = 6'(bin_q[idx]);
                // odd bins offer only the second half
                if (bin_q[idx] % 2 == 1)
                        fft2_valid = 1'b1;
                else
                        fft1_valid = 1'b1;
                for (int c = 0; c < watch_cycles; c++) begin
                        @(posedge clk);
                        #2;
                        if (raise_valid === 1'b1)
                                stop_with("raise_valid after a single valid input");
                end
                fft1_valid = 1'b0;
                fft2_valid = 1'b0;
        endtask

        initial begin
                clk = 1'b0;
                rst = 1'b1;
                fft1_data = '0;
                fft1_valid = 1'b0;
                fft2_data = '0;
                fft2_valid = 1'b0;
                freq1 = '0;
                cycle_count = 0;
                cycle_limit = 100;
                read_stimulus();
                cycle_limit = 30 * mode_q.size() + 100;
                repeat (10) @(posedge clk);
                #2;
                rst = 1'b0;
                check_value("raise_valid", int'(raise_valid), 0, 0);
                check_value("raise_fin", int'(raise_fin), 0, 0);
                check_value("raise_data", int'(raise_data), 0, 0);
                check_value("freq_out", int'(freq_out), 0, 0);
                for (int i = 0; i < mode_q.size(); i++) begin
                        case (mode_q[i])
                                0: apply_pair(i, 1'b0);
                                1: apply_single(i);
                                default: apply_pair(i, 1'b1);
                        endcase
                end
                $display("TESTS PASSED");
                $finish;
        end

endmodule

// ==== sim/raise_freq_input.txt ====
# mode bin fft1_re fft1_im fft2_re fft2_im exp_re exp_im tol
# mode is pair, single (one valid only) or spacing (second pair offered while busy)
pair 5 300 0 260 150 260 150 30
pair 5 212 212 150 260 212 212 40
pair 12 0 300 -260 -150 -150 260 30
pair 12 260 -150 -212 212 78 -290 40
spacing 20 300 0 -150 260 -150 260 30
single 20 100 0 0 100 0 0 0
pair 20 150 -260 -260 150 260 -150 40
pair 63 200 0 0 -300 0 -300 30
pair 0 -212 -212 -300 0 212 -212 30
pair 63 -150 -260 212 -212 290 -78 40
spacing 0 260 150 -212 -212 -260 150 40
single 1 0 200 0 200 0 0 0
pair 33 -300 0 260 150 -260 -150 30
pair 33 -300 0 260 150 150 260 40
pair 40 0 -300 0 300 -300 0 30
pair 40 212 212 -150 260 -78 -290 40
pair 63 300 0 150 260 212 212 40
single 63 50 50 50 50 0 0 0
pair 7 100 100 -100 0 -71 71 30
pair 7 0 200 0 -250 177 -177 40
spacing 62 260 150 300 0 260 -150 30
pair 5 -150 260 -260 -150 -212 212 45

// ==== raise_freq_top.f ====
logic/raise_freq_pkg.sv
logic/iter_counter.sv
logic/bin_ctrl.sv
logic/cordic_vector.sv
logic/phase_store.sv
logic/cordic_rotate.sv
logic/raise_freq_top.sv
sim/raise_freq_asserts.sv
sim/raise_freq_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= raise_freq_tb
FILELIST ?= raise_freq_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
